/* mips_pkg.sv */
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    localparam logic [REG_ADDR_W-1:0] REG_ZERO = '0;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field under SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'b000000,
        FUNCT_SRL  = 6'b000010,
        FUNCT_SRA  = 6'b000011,
        FUNCT_SLLV = 6'b000100,
        FUNCT_SRLV = 6'b000110,
        FUNCT_SRAV = 6'b000111,
        FUNCT_ADD  = 6'b100000,
        FUNCT_ADDU = 6'b100001,
        FUNCT_SUB  = 6'b100010,
        FUNCT_SUBU = 6'b100011,
        FUNCT_AND  = 6'b100100,
        FUNCT_OR   = 6'b100101,
        FUNCT_XOR  = 6'b100110,
        FUNCT_NOR  = 6'b100111,
        FUNCT_SLT  = 6'b101010,
        FUNCT_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_SLLV  = 8'b00000100,
        ALU_SRLV  = 8'b00000110,
        ALU_SRAV  = 8'b00000111,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_LUI   = 8'b01011100,
        ALU_SLL   = 8'b01111100
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_e;

endpackage

/* regfile.sv */
module regfile (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            we_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [mips_pkg::DATA_W-1:0]     wdata_i,
    input  logic                            re1_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic                            re2_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [mips_pkg::DATA_W-1:0]     rdata1_o,
    output logic [mips_pkg::DATA_W-1:0]     rdata2_o
);
    import mips_pkg::*;

    logic [DATA_W-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != REG_ZERO) begin // r0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic logic [DATA_W-1:0] read_port(
        input logic                  re,
        input logic [REG_ADDR_W-1:0] addr
    );
        if (!re || addr == REG_ZERO)
            return '0;
        if (we_i && addr == waddr_i)
            return wdata_i;                             // write-back bypass
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(re1_i, raddr1_i);
        rdata2_o = read_port(re2_i, raddr2_i);
    end

endmodule

/* inst_decoder.sv */
module inst_decoder (
    input  logic [mips_pkg::DATA_W-1:0]     inst_i,
    output logic                            reg1_read_o,
    output logic                            reg2_read_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] reg1_addr_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] reg2_addr_o,
    output logic [mips_pkg::DATA_W-1:0]     imm_o,
    output mips_pkg::aluop_e                aluop_o,
    output mips_pkg::alusel_e               alusel_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] wd_o,
    output logic                            wreg_o,
    output logic                            inst_valid_o
);
    import mips_pkg::*;

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] sa;
    aluop_e                reg_op;    // rs/rt register forms
    aluop_e                shift_op;  // shift by sa
    aluop_e                imm_op;    // I-type forms

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign sa     = inst_i[10:6];
    assign funct  = inst_i[5:0];

    always_comb begin
        reg_op   = ALU_NOP;
        shift_op = ALU_NOP;
        case (funct)
            FUNCT_AND:  reg_op = ALU_AND;
            FUNCT_OR:   reg_op = ALU_OR;
            FUNCT_XOR:  reg_op = ALU_XOR;
            FUNCT_NOR:  reg_op = ALU_NOR;
            FUNCT_SLLV: reg_op = ALU_SLLV;
            FUNCT_SRLV: reg_op = ALU_SRLV;
            FUNCT_SRAV: reg_op = ALU_SRAV;
            FUNCT_ADD:  reg_op = ALU_ADD;
            FUNCT_ADDU: reg_op = ALU_ADDU;
            FUNCT_SUB:  reg_op = ALU_SUB;
            FUNCT_SUBU: reg_op = ALU_SUBU;
            FUNCT_SLT:  reg_op = ALU_SLT;
            FUNCT_SLTU: reg_op = ALU_SLTU;
            FUNCT_SLL:  shift_op = ALU_SLL;
            FUNCT_SRL:  shift_op = ALU_SRL;
            FUNCT_SRA:  shift_op = ALU_SRA;
            default:    reg_op = ALU_NOP;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ANDI:  imm_op = ALU_AND;
            OP_ORI:   imm_op = ALU_OR;
            OP_XORI:  imm_op = ALU_XOR;
            OP_LUI:   imm_op = ALU_LUI;
            OP_ADDI:  imm_op = ALU_ADDI;
            OP_ADDIU: imm_op = ALU_ADDIU;
            OP_SLTI:  imm_op = ALU_SLT;   // immediate forms share the register op
            OP_SLTIU: imm_op = ALU_SLTU;
            default:  imm_op = ALU_NOP;
        endcase
    end

    always_comb begin
        reg1_read_o  = 1'b0;
        reg2_read_o  = 1'b0;
        reg1_addr_o  = rs;
        reg2_addr_o  = rt;
        wd_o         = rd;
        wreg_o       = 1'b0;
        imm_o        = '0;
        aluop_o      = ALU_NOP;
        inst_valid_o = 1'b0;

        if (opcode == OP_SPECIAL && sa == '0 && reg_op != ALU_NOP) begin
            aluop_o      = reg_op;
            reg1_read_o  = 1'b1;
            reg2_read_o  = 1'b1;
            wreg_o       = 1'b1;
            inst_valid_o = 1'b1;
        end

        // sll/srl/sra need rs and opcode all zero
        if (inst_i[31:21] == '0 && shift_op != ALU_NOP) begin
            aluop_o      = shift_op;
            reg2_read_o  = 1'b1;
            imm_o        = {{(DATA_W-REG_ADDR_W){1'b0}}, sa}; // goes out on reg1
            wreg_o       = 1'b1;
            inst_valid_o = 1'b1;
        end

        if (imm_op != ALU_NOP) begin
            aluop_o      = imm_op;
            reg1_read_o  = 1'b1;
            wd_o         = rt;
            wreg_o       = 1'b1;
            inst_valid_o = 1'b1;
            case (opcode)
                OP_ANDI, OP_ORI, OP_XORI: imm_o = {16'b0, inst_i[15:0]};
                OP_LUI:                   imm_o = {inst_i[15:0], 16'b0};
                default:                  imm_o = {{16{inst_i[15]}}, inst_i[15:0]};
            endcase
        end
    end

    always_comb begin
        case (aluop_o)
            ALU_NOP:                                 alusel_o = SEL_NOP;
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
            ALU_LUI:                                 alusel_o = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV,
            ALU_SRLV, ALU_SRAV:                      alusel_o = SEL_SHIFT;
            default:                                 alusel_o = SEL_ARITH;
        endcase
    end

endmodule

/* operand_select.sv */
module operand_select (
    input  logic                            read_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [mips_pkg::DATA_W-1:0]     reg_data_i,
    input  logic [mips_pkg::DATA_W-1:0]     imm_i,
    input  logic                            ex_wreg_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_wd_i,
    input  logic [mips_pkg::DATA_W-1:0]     ex_wdata_i,
    input  logic                            mem_wreg_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] mem_wd_i,
    input  logic [mips_pkg::DATA_W-1:0]     mem_wdata_i,
    output logic [mips_pkg::DATA_W-1:0]     operand_o
);
    import mips_pkg::*;

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

    // youngest producer wins
    always_comb begin
        if (!read_i)
            operand_o = imm_i;
        else if (ex_hit)
            operand_o = ex_wdata_i;
        else if (mem_hit)
            operand_o = mem_wdata_i;
        else
            operand_o = reg_data_i;
    end

endmodule

/* id_ex_reg.sv */
module id_ex_reg (
    input  logic                            clk,
    input  logic                            reset_i,
    input  mips_pkg::aluop_e                aluop_i,
    input  mips_pkg::alusel_e               alusel_i,
    input  logic [mips_pkg::DATA_W-1:0]     reg1_i,
    input  logic [mips_pkg::DATA_W-1:0]     reg2_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                            wreg_i,
    input  logic                            inst_valid_i,
    output mips_pkg::aluop_e                ex_aluop_o,
    output mips_pkg::alusel_e               ex_alusel_o,
    output logic [mips_pkg::DATA_W-1:0]     ex_reg1_o,
    output logic [mips_pkg::DATA_W-1:0]     ex_reg2_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] ex_wd_o,
    output logic                            ex_wreg_o,
    output logic                            ex_inst_valid_o
);
    import mips_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_aluop_o      <= ALU_NOP;
            ex_alusel_o     <= SEL_NOP;
            ex_reg1_o       <= '0;
            ex_reg2_o       <= '0;
            ex_wd_o         <= '0;
            ex_wreg_o       <= 1'b0;
            ex_inst_valid_o <= 1'b0;
        end else begin
            ex_aluop_o      <= aluop_i;
            ex_alusel_o     <= alusel_i;
            ex_reg1_o       <= reg1_i;
            ex_reg2_o       <= reg2_i;
            ex_wd_o         <= wd_i;
            ex_wreg_o       <= wreg_i;
            ex_inst_valid_o <= inst_valid_i;
        end
    end

endmodule

/* id_stage.sv */
module id_stage (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [mips_pkg::DATA_W-1:0]     inst_i,
    input  logic                            wb_we_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [mips_pkg::DATA_W-1:0]     wb_data_i,
    input  logic                            ex_wreg_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_wd_i,
    input  logic [mips_pkg::DATA_W-1:0]     ex_wdata_i,
    input  logic                            mem_wreg_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] mem_wd_i,
    input  logic [mips_pkg::DATA_W-1:0]     mem_wdata_i,
    output mips_pkg::aluop_e                ex_aluop_o,
    output mips_pkg::alusel_e               ex_alusel_o,
    output logic [mips_pkg::DATA_W-1:0]     ex_reg1_o,
    output logic [mips_pkg::DATA_W-1:0]     ex_reg2_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] ex_wd_o,
    output logic                            ex_wreg_o,
    output logic                            ex_inst_valid_o
);
    import mips_pkg::*;

    logic                  reg1_read;
    logic                  reg2_read;
    logic [REG_ADDR_W-1:0] reg1_addr;
    logic [REG_ADDR_W-1:0] reg2_addr;
    logic [DATA_W-1:0]     imm;
    aluop_e                aluop;
    alusel_e               alusel;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic                  inst_valid;
    logic [DATA_W-1:0]     rdata1;
    logic [DATA_W-1:0]     rdata2;
    logic [DATA_W-1:0]     reg1;
    logic [DATA_W-1:0]     reg2;

    regfile regfile_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .re1_i    (reg1_read),
        .raddr1_i (reg1_addr),
        .re2_i    (reg2_read),
        .raddr2_i (reg2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    inst_decoder inst_decoder_inst (
        .inst_i       (inst_i),
        .reg1_read_o  (reg1_read),
        .reg2_read_o  (reg2_read),
        .reg1_addr_o  (reg1_addr),
        .reg2_addr_o  (reg2_addr),
        .imm_o        (imm),
        .aluop_o      (aluop),
        .alusel_o     (alusel),
        .wd_o         (wd),
        .wreg_o       (wreg),
        .inst_valid_o (inst_valid)
    );

    operand_select operand1_inst (
        .read_i      (reg1_read),
        .addr_i      (reg1_addr),
        .reg_data_i  (rdata1),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1)
    );

    operand_select operand2_inst (
        .read_i      (reg2_read),
        .addr_i      (reg2_addr),
        .reg_data_i  (rdata2),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2)
    );

    id_ex_reg id_ex_reg_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .aluop_i         (aluop),
        .alusel_i        (alusel),
        .reg1_i          (reg1),
        .reg2_i          (reg2),
        .wd_i            (wd),
        .wreg_i          (wreg),
        .inst_valid_i    (inst_valid),
        .ex_aluop_o      (ex_aluop_o),
        .ex_alusel_o     (ex_alusel_o),
        .ex_reg1_o       (ex_reg1_o),
        .ex_reg2_o       (ex_reg2_o),
        .ex_wd_o         (ex_wd_o),
        .ex_wreg_o       (ex_wreg_o),
        .ex_inst_valid_o (ex_inst_valid_o)
    );

endmodule

/* id_stage_props.sv */
module id_stage_props (
    input logic                            clk,
    input logic                            reset_i,
    input logic [mips_pkg::DATA_W-1:0]     inst_i,
    input logic                            wb_we_i,
    input logic [mips_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input logic [mips_pkg::DATA_W-1:0]     wb_data_i,
    input logic                            ex_wreg_i,
    input logic [mips_pkg::REG_ADDR_W-1:0] ex_wd_i,
    input logic [mips_pkg::DATA_W-1:0]     ex_wdata_i,
    input logic                            mem_wreg_i,
    input logic [mips_pkg::REG_ADDR_W-1:0] mem_wd_i,
    input logic [mips_pkg::DATA_W-1:0]     mem_wdata_i,
    input mips_pkg::aluop_e                out_aluop_i,
    input mips_pkg::alusel_e               out_alusel_i,
    input logic [mips_pkg::DATA_W-1:0]     out_reg1_i,
    input logic [mips_pkg::DATA_W-1:0]     out_reg2_i,
    input logic [mips_pkg::REG_ADDR_W-1:0] out_wd_i,
    input logic                            out_wreg_i,
    input logic                            out_valid_i
);
    import mips_pkg::*;

    int unsigned fail_count = 0;    // assertion failures so far

    logic [DATA_W-1:0]     shadow [REG_COUNT];
    aluop_e                exp_op;
    alusel_e               exp_sel;
    logic                  exp_valid;
    logic [REG_ADDR_W-1:0] exp_wd;
    logic [DATA_W-1:0]     exp_imm;
    logic                  use_rs;
    logic                  use_rt;
    logic [DATA_W-1:0]     exp_r1;
    logic [DATA_W-1:0]     exp_r2;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_we_i && wb_addr_i != REG_ZERO) begin
            shadow[wb_addr_i] <= wb_data_i;
        end
    end

    // EX and MEM forwarding first, then r0, then bypass
    function automatic logic [DATA_W-1:0] expect_read(input logic [REG_ADDR_W-1:0] addr);
        if (ex_wreg_i && ex_wd_i == addr)
            return ex_wdata_i;
        if (mem_wreg_i && mem_wd_i == addr)
            return mem_wdata_i;
        if (addr == REG_ZERO)
            return '0;
        if (wb_we_i && wb_addr_i == addr)
            return wb_data_i;
        return shadow[addr];
    endfunction

    always_comb begin
        exp_op  = ALU_NOP;
        exp_wd  = inst_i[15:11];
        exp_imm = '0;
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        case (inst_i[31:26])
            OP_SPECIAL: begin
                case (inst_i[5:0])
                    FUNCT_AND:  exp_op = ALU_AND;
                    FUNCT_OR:   exp_op = ALU_OR;
                    FUNCT_XOR:  exp_op = ALU_XOR;
                    FUNCT_NOR:  exp_op = ALU_NOR;
                    FUNCT_SLL:  exp_op = ALU_SLL;
                    FUNCT_SRL:  exp_op = ALU_SRL;
                    FUNCT_SRA:  exp_op = ALU_SRA;
                    FUNCT_SLLV: exp_op = ALU_SLLV;
                    FUNCT_SRLV: exp_op = ALU_SRLV;
                    FUNCT_SRAV: exp_op = ALU_SRAV;
                    FUNCT_ADD:  exp_op = ALU_ADD;
                    FUNCT_ADDU: exp_op = ALU_ADDU;
                    FUNCT_SUB:  exp_op = ALU_SUB;
                    FUNCT_SUBU: exp_op = ALU_SUBU;
                    FUNCT_SLT:  exp_op = ALU_SLT;
                    FUNCT_SLTU: exp_op = ALU_SLTU;
                    default:    exp_op = ALU_NOP;
                endcase
                if (exp_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                    use_rt  = 1'b1;
                    exp_imm = {27'd0, inst_i[10:6]};    // sa rides on reg1
                    if (inst_i[25:21] != 5'd0)
                        exp_op = ALU_NOP;
                end else if (inst_i[10:6] != 5'd0) begin
                    exp_op = ALU_NOP;
                end else begin
                    use_rs = 1'b1;
                    use_rt = 1'b1;
                end
            end
            OP_ANDI:  exp_op = ALU_AND;
            OP_ORI:   exp_op = ALU_OR;
            OP_XORI:  exp_op = ALU_XOR;
            OP_LUI:   exp_op = ALU_LUI;
            OP_ADDI:  exp_op = ALU_ADDI;
            OP_ADDIU: exp_op = ALU_ADDIU;
            OP_SLTI:  exp_op = ALU_SLT;
            OP_SLTIU: exp_op = ALU_SLTU;
            default:  exp_op = ALU_NOP;
        endcase

        if (inst_i[31:26] != OP_SPECIAL && exp_op != ALU_NOP) begin
            use_rs = 1'b1;
            exp_wd = inst_i[20:16];    // I-type writes rt
            if (exp_op == ALU_LUI)
                exp_imm = {inst_i[15:0], 16'h0000};
            else if (exp_op inside {ALU_AND, ALU_OR, ALU_XOR})
                exp_imm = {16'h0000, inst_i[15:0]};
            else
                exp_imm = {{16{inst_i[15]}}, inst_i[15:0]};
        end

        if (exp_op == ALU_NOP) begin
            use_rs  = 1'b0;
            use_rt  = 1'b0;
            exp_imm = '0;
        end
        exp_valid = (exp_op != ALU_NOP);

        case (exp_op)
            ALU_NOP:                                      exp_sel = SEL_NOP;
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI:   exp_sel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA,
            ALU_SLLV, ALU_SRLV, ALU_SRAV:                 exp_sel = SEL_SHIFT;
            default:                                      exp_sel = SEL_ARITH;
        endcase
    end

    always_comb begin
        exp_r1 = use_rs ? expect_read(inst_i[25:21]) : exp_imm;
        exp_r2 = use_rt ? expect_read(inst_i[20:16]) : exp_imm;
    end

    reset_clear: assert property (@(posedge clk) disable iff (reset_i)
        $past(reset_i) |-> (!out_wreg_i && !out_valid_i && out_aluop_i == ALU_NOP
                            && out_alusel_i == SEL_NOP))
        else begin
            fail_count++;
            $error("Fail %0t: ID/EX outputs not cleared after reset", $time);
        end

    decode_ok: assert property (@(posedge clk) disable iff (reset_i)
        !$past(reset_i) |-> (out_aluop_i == $past(exp_op) && out_alusel_i == $past(exp_sel)
                             && out_wreg_i == $past(exp_valid) && out_wd_i == $past(exp_wd)
                             && out_valid_i == $past(exp_valid)))
        else begin
            fail_count++;
            $error("Fail %0t: decode mismatch, aluop %0h wd %0d", $time, out_aluop_i, out_wd_i);
        end

    reg1_ok: assert property (@(posedge clk) disable iff (reset_i)
        !$past(reset_i) |-> out_reg1_i == $past(exp_r1))
        else begin
            fail_count++;
            $error("Fail %0t: reg1 operand %h, expected %h", $time, out_reg1_i, $past(exp_r1));
        end

    reg2_ok: assert property (@(posedge clk) disable iff (reset_i)
        !$past(reset_i) |-> out_reg2_i == $past(exp_r2))
        else begin
            fail_count++;
            $error("Fail %0t: reg2 operand %h, expected %h", $time, out_reg2_i, $past(exp_r2));
        end

endmodule

bind id_stage id_stage_props props_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_i       (inst_i),
    .wb_we_i      (wb_we_i),
    .wb_addr_i    (wb_addr_i),
    .wb_data_i    (wb_data_i),
    .ex_wreg_i    (ex_wreg_i),
    .ex_wd_i      (ex_wd_i),
    .ex_wdata_i   (ex_wdata_i),
    .mem_wreg_i   (mem_wreg_i),
    .mem_wd_i     (mem_wd_i),
    .mem_wdata_i  (mem_wdata_i),
    .out_aluop_i  (ex_aluop_o),
    .out_alusel_i (ex_alusel_o),
    .out_reg1_i   (ex_reg1_o),
    .out_reg2_i   (ex_reg2_o),
    .out_wd_i     (ex_wd_o),
    .out_wreg_i   (ex_wreg_o),
    .out_valid_i  (ex_inst_valid_o)
);

/* tb_id_stage.sv */
module tb_id_stage;
    import mips_pkg::*;

    localparam int WAIT_LIMIT = 8;

    logic                  clk;
    logic                  reset;
    logic [DATA_W-1:0]     inst;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    logic                  ex_wreg;
    logic [REG_ADDR_W-1:0] ex_wd;
    logic [DATA_W-1:0]     ex_wdata;
    logic                  mem_wreg;
    logic [REG_ADDR_W-1:0] mem_wd;
    logic [DATA_W-1:0]     mem_wdata;
    aluop_e                out_aluop;
    alusel_e               out_alusel;
    logic [DATA_W-1:0]     out_reg1;
    logic [DATA_W-1:0]     out_reg2;
    logic [REG_ADDR_W-1:0] out_wd;
    logic                  out_wreg;
    logic                  out_valid;
    int                    seed;
    int                    timeout_count;
    int                    error_count;
    logic [REG_ADDR_W-1:0] a;
    logic [REG_ADDR_W-1:0] b;

    funct_e  r_functs [13] = '{FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_NOR, FUNCT_SLLV,
                               FUNCT_SRLV, FUNCT_SRAV, FUNCT_ADD, FUNCT_ADDU, FUNCT_SUB,
                               FUNCT_SUBU, FUNCT_SLT, FUNCT_SLTU};
    funct_e  shift_functs [3] = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA};
    opcode_e i_ops [8] = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU,
                           OP_SLTI, OP_SLTIU};

    id_stage id_stage_inst (
        .clk             (clk),
        .reset_i         (reset),
        .inst_i          (inst),
        .wb_we_i         (wb_we),
        .wb_addr_i       (wb_addr),
        .wb_data_i       (wb_data),
        .ex_wreg_i       (ex_wreg),
        .ex_wd_i         (ex_wd),
        .ex_wdata_i      (ex_wdata),
        .mem_wreg_i      (mem_wreg),
        .mem_wd_i        (mem_wd),
        .mem_wdata_i     (mem_wdata),
        .ex_aluop_o      (out_aluop),
        .ex_alusel_o     (out_alusel),
        .ex_reg1_o       (out_reg1),
        .ex_reg2_o       (out_reg2),
        .ex_wd_o         (out_wd),
        .ex_wreg_o       (out_wreg),
        .ex_inst_valid_o (out_valid)
    );

    always #10 clk = ~clk;

    function automatic logic [REG_ADDR_W-1:0] rand_reg();
        return REG_ADDR_W'($random(seed));
    endfunction

    function automatic logic [DATA_W-1:0] r_word(input funct_e funct,
                                                 input logic [REG_ADDR_W-1:0] rs,
                                                 input logic [REG_ADDR_W-1:0] rt);
        return {OP_SPECIAL, rs, rt, rand_reg(), 5'd0, funct};
    endfunction

    function automatic logic [DATA_W-1:0] shift_word(input funct_e funct);
        return {11'd0, rand_reg(), rand_reg(), rand_reg(), funct};
    endfunction

    function automatic logic [DATA_W-1:0] i_word(input opcode_e op);
        return {op, rand_reg(), rand_reg(), 16'($random(seed))};
    endfunction

    // present one word, then wait until ID/EX shows the expected valid flag
    task automatic issue(input logic [DATA_W-1:0] word, input logic want_valid);
        int cycles;
        inst   = word;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (out_valid !== want_valid && cycles < WAIT_LIMIT);
        if (out_valid !== want_valid) begin
            timeout_count++;
            $display("timeout waiting for ex_inst_valid_o=%0b after instruction %h at %0t",
                     want_valid, word, $time);
        end
    endtask

    initial begin
        seed          = 32352;
        timeout_count = 0;
        clk           = 1'b0;
        reset         = 1'b1;
        inst          = '0;
        wb_we         = 1'b0;
        wb_addr       = '0;
        wb_data       = '0;
        ex_wreg       = 1'b0;
        ex_wd         = '0;
        ex_wdata      = '0;
        mem_wreg      = 1'b0;
        mem_wd        = '0;
        mem_wdata     = '0;
        a             = '0;
        b             = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // preload every register including a dropped r0 write
        for (int r = 0; r < REG_COUNT; r++) begin
            wb_we   = 1'b1;
            wb_addr = REG_ADDR_W'(r);
            wb_data = $random(seed);
            issue(32'hffff_ffff, 1'b0);
        end
        wb_we = 1'b0;

        for (int n = 0; n < 4; n++) begin
            foreach (r_functs[i]) issue(r_word(r_functs[i], rand_reg(), rand_reg()), 1'b1);
            foreach (shift_functs[i]) issue(shift_word(shift_functs[i]), 1'b1);
            foreach (i_ops[i]) issue(i_word(i_ops[i]), 1'b1);
        end

        for (int n = 0; n < 6; n++) begin
            a         = rand_reg();
            b         = rand_reg();
            ex_wreg   = 1'b1;
            ex_wd     = a;
            ex_wdata  = $random(seed);
            mem_wreg  = 1'b1;
            mem_wd    = a;
            mem_wdata = $random(seed);
            wb_we     = 1'b1;
            wb_addr   = a;
            wb_data   = $random(seed);
            issue(r_word(FUNCT_ADDU, a, b), 1'b1);     // EX beats MEM
            ex_wreg = 1'b0;
            issue(r_word(FUNCT_SUB, b, a), 1'b1);      // MEM only
            mem_wreg = 1'b0;
            wb_data  = $random(seed);                  // differs from the stored word
            issue(r_word(FUNCT_OR, a, a), 1'b1);       // same-cycle write-back
            wb_we = 1'b0;
            issue(r_word(FUNCT_SLT, a, b), 1'b1);
        end

        wb_we   = 1'b1;
        wb_addr = REG_ZERO;
        wb_data = $random(seed);
        issue(r_word(FUNCT_ADD, REG_ZERO, REG_ZERO), 1'b1);
        wb_we = 1'b0;
        issue(r_word(FUNCT_XOR, REG_ZERO, rand_reg()), 1'b1);

        issue({6'h3f, 26'($random(seed))}, 1'b0);
        issue({6'h23, 26'($random(seed))}, 1'b0);  // lw, not kept
        issue({OP_SPECIAL, rand_reg(), rand_reg(), rand_reg(), 5'd0, 6'h01}, 1'b0);
        issue({OP_SPECIAL, rand_reg(), rand_reg(), rand_reg(), 5'd3, FUNCT_AND}, 1'b0);
        issue({OP_SPECIAL, 5'd7, rand_reg(), rand_reg(), 5'd2, FUNCT_SLL}, 1'b0);
        repeat (2) @(negedge clk);    // last capture still gets checked

        error_count = id_stage_inst.props_inst.fail_count + timeout_count;
        $display("checks done: %0d assertion failures, %0d timeouts",
                 id_stage_inst.props_inst.fail_count, timeout_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
mips_pkg.sv
regfile.sv
inst_decoder.sv
operand_select.sv
id_ex_reg.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

/* Makefile */
TOP := tb_id_stage

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "Test completed successfully"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
